// File: logic/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 64;
    localparam int LINE_W   = 256;
    localparam int BEATS    = 4;   // words per line, also axi beats per burst
    localparam int SETS     = 16;
    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 23;  // ADDR_W - INDEX_W - OFFSET_W
    localparam int STRB_W   = 8;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;   // one core word, one axi beat
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [1:0]          beat_t;   // word position inside a line

    // core request, one in flight
    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
        strb_t wmask;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
    } cpu_resp_t;

    // whole-line transfer between miss sequencer and bus stage
    typedef struct packed {
        addr_t addr;    // line aligned
        logic  write;
        line_t line;
    } line_cmd_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_WAIT_FILL,
        LK_RESPOND
    } lookup_state_e;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WRITEBACK,
        MS_REFILL,
        MS_DONE
    } miss_state_e;

    typedef enum logic [1:0] {
        W_IDLE,
        W_AW,
        W_DATA,
        W_RESP
    } bus_w_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_AR,
        R_DATA
    } bus_r_state_e;

endpackage

// File: logic/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      req_valid_i,
    input  cpu_req_t  req_i,
    input  logic      fill_valid_i,
    input  line_t     fill_line_i,
    output logic      resp_valid_o,
    output cpu_resp_t resp_o,
    output logic      miss_valid_o,
    output addr_t     miss_addr_o,
    output logic      victim_dirty_o,
    output addr_t     victim_addr_o,
    output line_t     victim_line_o
);

    lookup_state_e   state_q;
    cpu_req_t        req_q;        // held until the response goes out

    tag_t            tag_q  [SETS];
    line_t           data_q [SETS];
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    tag_t   req_tag;
    index_t req_index;
    beat_t  req_word;
    logic   hit;
    line_t  base_line;
    word_t  old_word;
    line_t  new_line;

    // byte-wise store merge
    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t mask);
        word_t res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign req_word  = req_q.addr[OFFSET_W-1 -: 2];    // bits 4:3

    assign hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

    // while waiting the fill line replaces the array line
    assign base_line = (state_q == LK_WAIT_FILL) ? fill_line_i : data_q[req_index];
    assign old_word  = base_line[req_word*WORD_W +: WORD_W];

    always_comb begin
        new_line = base_line;
        new_line[req_word*WORD_W +: WORD_W] = merge_word(old_word, req_q.wdata, req_q.wmask);
    end

    // miss record, stable while in LK_WAIT_FILL
    assign miss_addr_o    = {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign victim_dirty_o = valid_q[req_index] & dirty_q[req_index];
    assign victim_addr_o  = {tag_q[req_index], req_index, {OFFSET_W{1'b0}}};
    assign victim_line_o  = data_q[req_index];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q      <= LK_IDLE;
            resp_valid_o <= 1'b0;
            miss_valid_o <= 1'b0;
            valid_q      <= '0;
            dirty_q      <= '0;
        end else begin
            resp_valid_o <= 1'b0;    // both are one-cycle strobes
            miss_valid_o <= 1'b0;
            case (state_q)
                LK_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= LK_RESPOND;
                    end
                end
                LK_RESPOND: begin    // tag compare on the held request
                    if (hit) begin
                        resp_valid_o <= 1'b1;
                        if (req_q.write) begin
                            dirty_q[req_index] <= 1'b1;
                        end
                        state_q <= LK_IDLE;
                    end else begin
                        miss_valid_o <= 1'b1;
                        state_q      <= LK_WAIT_FILL;
                    end
                end
                LK_WAIT_FILL: begin
                    if (fill_valid_i) begin
                        resp_valid_o       <= 1'b1;
                        valid_q[req_index] <= 1'b1;
                        dirty_q[req_index] <= req_q.write;   // clean unless store pending
                        state_q            <= LK_IDLE;
                    end
                end
                default: state_q <= LK_IDLE;
            endcase
        end
    end

    // arrays and response payload
    always_ff @(posedge clock) begin
        if (state_q == LK_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == LK_RESPOND && hit) begin
            resp_o.rdata <= old_word;    // value before the store
            resp_o.hit   <= 1'b1;
            if (req_q.write) begin
                data_q[req_index] <= new_line;
            end
        end
        if (state_q == LK_WAIT_FILL && fill_valid_i) begin
            resp_o.rdata      <= old_word;
            resp_o.hit        <= 1'b0;
            data_q[req_index] <= req_q.write ? new_line : fill_line_i;
            tag_q[req_index]  <= req_tag;
        end
    end

endmodule

// File: logic/dcache_miss_seq.sv
`timescale 1ns/1ps

module dcache_miss_seq
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      miss_valid_i,
    input  addr_t     miss_addr_i,
    input  logic      victim_dirty_i,
    input  addr_t     victim_addr_i,
    input  line_t     victim_line_i,
    input  logic      done_valid_i,
    input  line_t     rd_line_i,
    output logic      fill_valid_o,
    output line_t     fill_line_o,
    output logic      cmd_valid_o,
    output line_cmd_t cmd_o
);

    miss_state_e state_q;
    addr_t       refill_addr_q;    // line to fetch once the victim is out

    // fill strobe is the single cycle spent in MS_DONE
    assign fill_valid_o = (state_q == MS_DONE);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q     <= MS_IDLE;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                MS_IDLE: begin
                    if (miss_valid_i) begin
                        cmd_valid_o <= 1'b1;    // writeback or refill, one cycle later
                        state_q     <= victim_dirty_i ? MS_WRITEBACK : MS_REFILL;
                    end
                end
                MS_WRITEBACK: begin
                    if (done_valid_i) begin
                        cmd_valid_o <= 1'b1;    // victim written, now fetch
                        state_q     <= MS_REFILL;
                    end
                end
                MS_REFILL: begin
                    if (done_valid_i) begin
                        state_q <= MS_DONE;
                    end
                end
                MS_DONE: begin
                    state_q <= MS_IDLE;
                end
                default: state_q <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == MS_IDLE && miss_valid_i) begin
            refill_addr_q <= miss_addr_i;
            cmd_o.addr    <= victim_dirty_i ? victim_addr_i : miss_addr_i;
            cmd_o.write   <= victim_dirty_i;
            cmd_o.line    <= victim_line_i;    // don't care on a read command
        end
        if (state_q == MS_WRITEBACK && done_valid_i) begin
            cmd_o.addr  <= refill_addr_q;
            cmd_o.write <= 1'b0;
        end
        if (state_q == MS_REFILL && done_valid_i) begin
            fill_line_o <= rd_line_i;
        end
    end

endmodule

// File: logic/axi_dcache_bridge.sv
`timescale 1ns/1ps

module axi_dcache_bridge
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      cmd_valid_i,
    input  line_cmd_t cmd_i,
    output logic      done_valid_o,
    output line_t     rd_line_o,

    // write address / data / response
    input  logic      axi_aw_ready_i,
    output logic      axi_aw_valid_o,
    output addr_t     axi_aw_addr_o,
    input  logic      axi_w_ready_i,
    output logic      axi_w_valid_o,
    output word_t     axi_w_data_o,
    output strb_t     axi_w_strb_o,
    output logic      axi_w_last_o,
    output logic      axi_b_ready_o,
    input  logic      axi_b_valid_i,
    input  logic [1:0] axi_b_resp_i,    // error responses are ignored

    // read address / data
    input  logic      axi_ar_ready_i,
    output logic      axi_ar_valid_o,
    output addr_t     axi_ar_addr_o,
    output logic      axi_r_ready_o,
    input  logic      axi_r_valid_i,
    input  word_t     axi_r_data_i,
    input  logic      axi_r_last_i,
    input  logic [1:0] axi_r_resp_i     // likewise ignored
);

    bus_w_state_e w_state_q, w_state_d;
    bus_r_state_e r_state_q, r_state_d;

    beat_t w_cnt_q;
    beat_t r_cnt_q;
    addr_t wr_addr_q;
    addr_t rd_addr_q;
    line_t wr_line_q;
    logic  w_last;
    logic  wr_start;
    logic  rd_start;

    assign wr_start = (w_state_q == W_IDLE) && cmd_valid_i && cmd_i.write;
    assign rd_start = (r_state_q == R_IDLE) && cmd_valid_i && !cmd_i.write;
    assign w_last   = (w_cnt_q == beat_t'(BEATS-1));

    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            W_IDLE: if (wr_start)                       w_state_d = W_AW;
            W_AW:   if (axi_aw_ready_i)                 w_state_d = W_DATA;
            W_DATA: if (axi_w_ready_i && w_last)        w_state_d = W_RESP;
            W_RESP: if (axi_b_valid_i)                  w_state_d = W_IDLE;
            default:                                    w_state_d = W_IDLE;
        endcase
    end

    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            R_IDLE: if (rd_start)                       r_state_d = R_AR;
            R_AR:   if (axi_ar_ready_i)                 r_state_d = R_DATA;
            R_DATA: if (axi_r_valid_i && axi_r_last_i)  r_state_d = R_IDLE;
            default:                                    r_state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q    <= W_IDLE;
            r_state_q    <= R_IDLE;
            w_cnt_q      <= '0;
            r_cnt_q      <= '0;
            done_valid_o <= 1'b0;
        end else begin
            w_state_q <= w_state_d;
            r_state_q <= r_state_d;
            if (wr_start) begin
                w_cnt_q <= '0;
            end else if (axi_w_valid_o && axi_w_ready_i && !w_last) begin
                w_cnt_q <= w_cnt_q + 2'd1;
            end
            if (rd_start) begin
                r_cnt_q <= '0;
            end else if (axi_r_valid_i && axi_r_ready_o) begin
                r_cnt_q <= r_cnt_q + 2'd1;
            end
            // strobe once the b response or last read beat is taken
            done_valid_o <= (axi_b_valid_i && axi_b_ready_o) ||
                            (axi_r_valid_i && axi_r_ready_o && axi_r_last_i);
        end
    end

    // command latch and read assembly
    always_ff @(posedge clock) begin
        if (wr_start) begin
            wr_addr_q <= cmd_i.addr;
            wr_line_q <= cmd_i.line;
        end
        if (rd_start) begin
            rd_addr_q <= cmd_i.addr;
        end
        if (axi_r_valid_i && axi_r_ready_o) begin
            rd_line_o[r_cnt_q*WORD_W +: WORD_W] <= axi_r_data_i;
        end
    end

    assign axi_aw_valid_o = (w_state_q == W_AW);
    assign axi_aw_addr_o  = wr_addr_q;
    assign axi_w_valid_o  = (w_state_q == W_DATA);
    assign axi_w_data_o   = wr_line_q[w_cnt_q*WORD_W +: WORD_W];
    assign axi_w_strb_o   = '1;    // full line, every byte
    assign axi_w_last_o   = axi_w_valid_o && w_last;
    assign axi_b_ready_o  = (w_state_q == W_RESP);

    assign axi_ar_valid_o = (r_state_q == R_AR);
    assign axi_ar_addr_o  = rd_addr_q;
    assign axi_r_ready_o  = (r_state_q == R_DATA);

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       req_valid_i,
    input  cpu_req_t   req_i,
    output logic       resp_valid_o,
    output cpu_resp_t  resp_o,

    input  logic       axi_aw_ready_i,
    output logic       axi_aw_valid_o,
    output addr_t      axi_aw_addr_o,
    input  logic       axi_w_ready_i,
    output logic       axi_w_valid_o,
    output word_t      axi_w_data_o,
    output strb_t      axi_w_strb_o,
    output logic       axi_w_last_o,
    output logic       axi_b_ready_o,
    input  logic       axi_b_valid_i,
    input  logic [1:0] axi_b_resp_i,
    input  logic       axi_ar_ready_i,
    output logic       axi_ar_valid_o,
    output addr_t      axi_ar_addr_o,
    output logic       axi_r_ready_o,
    input  logic       axi_r_valid_i,
    input  word_t      axi_r_data_i,
    input  logic       axi_r_last_i,
    input  logic [1:0] axi_r_resp_i
);

    // lookup <-> miss sequencer
    logic      miss_valid;
    addr_t     miss_addr;
    logic      victim_dirty;
    addr_t     victim_addr;
    line_t     victim_line;
    logic      fill_valid;
    line_t     fill_line;

    // miss sequencer <-> bridge
    logic      cmd_valid;
    line_cmd_t cmd;
    logic      done_valid;
    line_t     rd_line;

    dcache_lookup u_lookup (
        .clock          (clock),
        .reset          (reset),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .fill_valid_i   (fill_valid),
        .fill_line_i    (fill_line),
        .resp_valid_o   (resp_valid_o),
        .resp_o         (resp_o),
        .miss_valid_o   (miss_valid),
        .miss_addr_o    (miss_addr),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .victim_line_o  (victim_line)
    );

    dcache_miss_seq u_miss_seq (
        .clock          (clock),
        .reset          (reset),
        .miss_valid_i   (miss_valid),
        .miss_addr_i    (miss_addr),
        .victim_dirty_i (victim_dirty),
        .victim_addr_i  (victim_addr),
        .victim_line_i  (victim_line),
        .done_valid_i   (done_valid),
        .rd_line_i      (rd_line),
        .fill_valid_o   (fill_valid),
        .fill_line_o    (fill_line),
        .cmd_valid_o    (cmd_valid),
        .cmd_o          (cmd)
    );

    axi_dcache_bridge u_bridge (
        .clock          (clock),
        .reset          (reset),
        .cmd_valid_i    (cmd_valid),
        .cmd_i          (cmd),
        .done_valid_o   (done_valid),
        .rd_line_o      (rd_line),
        .axi_aw_ready_i (axi_aw_ready_i),
        .axi_aw_valid_o (axi_aw_valid_o),
        .axi_aw_addr_o  (axi_aw_addr_o),
        .axi_w_ready_i  (axi_w_ready_i),
        .axi_w_valid_o  (axi_w_valid_o),
        .axi_w_data_o   (axi_w_data_o),
        .axi_w_strb_o   (axi_w_strb_o),
        .axi_w_last_o   (axi_w_last_o),
        .axi_b_ready_o  (axi_b_ready_o),
        .axi_b_valid_i  (axi_b_valid_i),
        .axi_b_resp_i   (axi_b_resp_i),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_last_i   (axi_r_last_i),
        .axi_r_resp_i   (axi_r_resp_i)
    );

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  addr_t      aw_addr_i,
    input  logic       w_valid_i,
    output logic       w_ready_o,
    input  word_t      w_data_i,
    input  strb_t      w_strb_i,
    input  logic       w_last_i,
    output logic       b_valid_o,
    input  logic       b_ready_i,
    output logic [1:0] b_resp_o,
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    input  addr_t      ar_addr_i,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output word_t      r_data_o,
    output logic       r_last_o,
    output logic [1:0] r_resp_o
);

    localparam int WORDS = 512;    // 4 KiB of 64-bit words

    word_t      mem [WORDS];

    addr_t      wr_addr_q;
    beat_t      wr_beat_q;
    logic       wr_active_q;
    logic       b_pend_q;
    logic [1:0] b_wait_q;          // cycles left before b_valid
    addr_t      rd_addr_q;
    beat_t      rd_beat_q;
    logic       rd_active_q;
    logic [8:0] w_slot;
    logic [8:0] r_slot;

    // word slots wrap at 4 KiB
    assign w_slot   = wr_addr_q[11:3] + {7'd0, wr_beat_q};
    assign r_slot   = rd_addr_q[11:3] + {7'd0, rd_beat_q};
    assign b_resp_o = 2'b00;    // always OKAY
    assign r_resp_o = 2'b00;

    task automatic poke_word(input addr_t a, input word_t d);
        mem[a[11:3]] = d;
    endtask

    task automatic peek_word(input addr_t a, output word_t d);
        d = mem[a[11:3]];
    endtask

    // write address, data and response
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            aw_ready_o  <= 1'b0;
            w_ready_o   <= 1'b0;
            b_valid_o   <= 1'b0;
            wr_active_q <= 1'b0;
            wr_beat_q   <= '0;
            b_pend_q    <= 1'b0;
            b_wait_q    <= '0;
        end else begin
            if (aw_valid_i && aw_ready_o) begin
                wr_addr_q   <= aw_addr_i;
                wr_beat_q   <= '0;
                wr_active_q <= 1'b1;
                aw_ready_o  <= 1'b0;
            end else begin
                aw_ready_o <= !wr_active_q && !b_pend_q && !b_valid_o &&
                              ($urandom_range(0, 2) == 0);
            end
            if (w_valid_i && w_ready_o) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (w_strb_i[b]) begin
                        mem[w_slot][8*b +: 8] <= w_data_i[8*b +: 8];
                    end
                end
                wr_beat_q <= wr_beat_q + 2'd1;
                w_ready_o <= 1'b0;    // bubble after every beat
                if (w_last_i) begin
                    wr_active_q <= 1'b0;
                    b_pend_q    <= 1'b1;
                    b_wait_q    <= 2'($urandom_range(0, 3));
                end
            end else begin
                w_ready_o <= wr_active_q && ($urandom_range(0, 1) == 0);
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
            end else if (b_pend_q) begin
                if (b_wait_q == 2'd0) begin
                    b_valid_o <= 1'b1;
                    b_pend_q  <= 1'b0;
                end else begin
                    b_wait_q <= b_wait_q - 2'd1;
                end
            end
        end
    end

    // read address and data
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o  <= 1'b0;
            r_valid_o   <= 1'b0;
            r_last_o    <= 1'b0;
            r_data_o    <= '0;
            rd_active_q <= 1'b0;
            rd_beat_q   <= '0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                rd_addr_q   <= ar_addr_i;
                rd_beat_q   <= '0;
                rd_active_q <= 1'b1;
                ar_ready_o  <= 1'b0;
            end else begin
                ar_ready_o <= !rd_active_q && ($urandom_range(0, 2) == 0);
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                rd_beat_q <= rd_beat_q + 2'd1;
                if (r_last_o) begin
                    rd_active_q <= 1'b0;
                end
            end else if (rd_active_q && !r_valid_o && ($urandom_range(0, 2) == 0)) begin
                r_valid_o <= 1'b1;    // held until taken
                r_data_o  <= mem[r_slot];
                r_last_o  <= (rd_beat_q == 2'd3);
            end
        end
    end

endmodule

// File: test/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int SEED       = 32'h6f1b_b50a;
    localparam int TIMEOUT_NS = 200 * 100 * 40;    // accesses x cycles x period

    logic       clock;
    logic       reset;
    logic       req_valid_i;
    cpu_req_t   req;
    logic       resp_valid_o;
    cpu_resp_t  resp;

    logic       aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    logic       ar_valid, ar_ready, r_valid, r_ready, r_last;
    addr_t      aw_addr, ar_addr;
    word_t      w_data, r_data;
    strb_t      w_strb;
    logic [1:0] b_resp, r_resp;

    word_t           shadow [512];    // memory as the core sees it
    tag_t            tag_tab [SETS];
    logic [SETS-1:0] tag_vld;
    int              errors;
    int              checks;

    always #20 clock = ~clock;

    dcache_top DUT (
        .clock (clock), .reset (reset),
        .req_valid_i (req_valid_i), .req_i (req),
        .resp_valid_o (resp_valid_o), .resp_o (resp),
        .axi_aw_ready_i (aw_ready), .axi_aw_valid_o (aw_valid), .axi_aw_addr_o (aw_addr),
        .axi_w_ready_i (w_ready), .axi_w_valid_o (w_valid), .axi_w_data_o (w_data),
        .axi_w_strb_o (w_strb), .axi_w_last_o (w_last),
        .axi_b_ready_o (b_ready), .axi_b_valid_i (b_valid), .axi_b_resp_i (b_resp),
        .axi_ar_ready_i (ar_ready), .axi_ar_valid_o (ar_valid), .axi_ar_addr_o (ar_addr),
        .axi_r_ready_o (r_ready), .axi_r_valid_i (r_valid), .axi_r_data_i (r_data),
        .axi_r_last_i (r_last), .axi_r_resp_i (r_resp)
    );

    axi_mem_model u_mem (
        .clock (clock), .reset (reset),
        .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr),
        .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data),
        .w_strb_i (w_strb), .w_last_i (w_last),
        .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp),
        .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
        .r_last_o (r_last), .r_resp_o (r_resp)
    );

    function automatic word_t fill_pattern(addr_t a);
        return {a ^ 32'h5a3c_0f00, ~a};
    endfunction

    // expand the byte mask to bits, then blend
    function automatic word_t apply_mask(word_t old_w, word_t new_w, strb_t mask);
        word_t bits;
        for (int i = 0; i < WORD_W; i++) begin
            bits[i] = mask[i / 8];
        end
        return (old_w & ~bits) | (new_w & bits);
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %016h expected %016h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // called 1 ns after a rising edge, returns the same way
    task automatic do_access(input addr_t addr, input logic write, input word_t wdata,
                             input strb_t wmask, output int cycles);
        index_t idx;
        tag_t   tag;
        word_t  exp_data;
        logic   exp_hit;
        idx      = addr[8:5];
        tag      = addr[31:9];
        exp_data = shadow[addr[11:3]];
        exp_hit  = tag_vld[idx] && (tag_tab[idx] == tag);
        req.addr    = addr;
        req.write   = write;
        req.wdata   = wdata;
        req.wmask   = wmask;
        req_valid_i = 1'b1;
        @(posedge clock);
        #1;
        req_valid_i = 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (!resp_valid_o);
        check_word($sformatf("rdata at %08h", addr), resp.rdata, exp_data);
        check_flag($sformatf("hit at %08h", addr), resp.hit, exp_hit);
        if (write) begin
            shadow[addr[11:3]] = apply_mask(exp_data, wdata, wmask);
        end
        tag_vld[idx] = 1'b1;
        tag_tab[idx] = tag;
    endtask

    task automatic read_miss_refill();
        int cycles;
        u_mem.poke_word(32'h0000_0448, 64'h0123_4567_89ab_cdef);
        shadow[9'h089] = 64'h0123_4567_89ab_cdef;    // word of 0x448
        do_access(32'h0000_0448, 1'b0, '0, '0, cycles);
    endtask

    task automatic read_hit_latency();
        int cycles;
        do_access(32'h0000_0440, 1'b0, '0, '0, cycles);
        check_word("hit latency in cycles", word_t'(cycles), word_t'(1));
    endtask

    task automatic store_merge();
        int    cycles;
        word_t mem_word;
        do_access(32'h0000_0128, 1'b1, 64'hdead_beef_cafe_f00d, 8'b1010_0110, cycles);
        do_access(32'h0000_0128, 1'b0, '0, '0, cycles);
        u_mem.peek_word(32'h0000_0128, mem_word);
        check_word("memory behind dirty line", mem_word, fill_pattern(32'h0000_0128));
    endtask

    task automatic dirty_eviction();
        int    cycles;
        word_t mem_word;
        do_access(32'h0000_0130, 1'b1, 64'h1122_3344_5566_7788, 8'hff, cycles);
        do_access(32'h0000_0328, 1'b0, '0, '0, cycles);    // same set, next tag
        for (int w = 0; w < BEATS; w++) begin
            u_mem.peek_word(32'h0000_0120 + 8 * w, mem_word);
            check_word($sformatf("written back word %0d", w), mem_word,
                       shadow[9'h024 + w]);
        end
    endtask

    // two sets, four tags each
    task automatic random_mix();
        int    cycles;
        int    k;
        addr_t addr;
        for (int n = 0; n < 200; n++) begin
            k    = $urandom_range(0, 7);
            addr = (addr_t'(k >> 1) << 9) | (addr_t'((k & 1) ? 6 : 3) << 5) |
                   (addr_t'($urandom_range(0, 3)) << 3);
            do_access(addr, 1'($urandom_range(0, 1)), {$urandom, $urandom},
                      8'($urandom_range(1, 255)), cycles);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        addr_t a;
        void'($urandom(SEED));
        clock       = 1'b0;
        reset       = 1'b0;
        req_valid_i = 1'b0;
        req         = '0;
        errors      = 0;
        checks      = 0;
        tag_vld     = '0;
        for (int i = 0; i < 512; i++) begin
            a = addr_t'(i * 8);
            u_mem.poke_word(a, fill_pattern(a));
            shadow[i] = fill_pattern(a);
        end
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;
        @(posedge clock);
        #1;
        read_miss_refill();
        read_hit_latency();
        store_merge();
        dirty_eviction();
        random_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/dcache_pkg.sv
logic/dcache_lookup.sv
logic/dcache_miss_seq.sv
logic/axi_dcache_bridge.sv
logic/dcache_top.sv
test/axi_mem_model.sv
test/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/dcache_lookup.sv
  - logic/dcache_miss_seq.sv
  - logic/axi_dcache_bridge.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - test/axi_mem_model.sv
      - test/tb_dcache.sv
